// File: hdl/sd_proto_pkg.sv
package sd_proto_pkg;

    // ====================
    // Command frame layout
    // ====================

    // Start, transmission, index, argument, CRC7, end
    localparam int FRAME_BITS = 48;
    localparam int ARG_BITS   = 32;
    localparam int INDEX_BITS = 6;
    localparam int CRC_BITS   = 7;

    // Leading bits covered by the CRC7
    localparam int CRC_COVER_BITS = FRAME_BITS - CRC_BITS - 1;

    typedef logic [CRC_BITS-1:0] crc7_t;

    // x^7 + x^3 + 1
    localparam crc7_t CRC_POLY = 7'h09;

    // ====================
    // Request and response
    // ====================

    typedef enum logic {
        RESP_NONE = 1'b0,
        RESP_R48  = 1'b1
    } resp_kind_t;

    typedef struct packed {
        logic [INDEX_BITS-1:0] index;
        logic [ARG_BITS-1:0]   arg;
        resp_kind_t            resp_kind;
    } cmd_req_t;

    // Flags sit below the payload
    typedef struct packed {
        logic [INDEX_BITS-1:0] index;
        logic [ARG_BITS-1:0]   arg;
        logic                  crc_err;
        logic                  end_err;
        logic                  timeout;
    } cmd_resp_t;

endpackage

// File: hdl/sd_ctrl_pkg.sv
package sd_ctrl_pkg;

    // ====================
    // Sequencer states
    // ====================

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_START,
        RECV,
        DELIVER,
        GAP
    } seq_state_t;

    // ====================
    // Bit-time limits
    // ====================

    // Longest wait for the response start bit
    localparam int NCR_MAX  = 64;
    // Idle bits between two commands
    localparam int NCC_BITS = 8;

    // Holds any load value up to NCR_MAX
    typedef logic [6:0] bit_count_t;

endpackage

// File: hdl/sd_slot_reg.sv
`timescale 1ns/1ps

module sd_slot_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_fast,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic full;

    // Takes a new entry when empty or when the held one leaves this cycle
    assign in_ready  = ~full | out_ready;
    assign out_valid = full;

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk_fast) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: hdl/sd_bit_timer.sv
`timescale 1ns/1ps

module sd_bit_timer
    import sd_ctrl_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic       clk_fast,
    input  logic       arst_n,
    output logic       sd_clk,
    output logic       tick_rise,
    output logic       tick_fall,
    input  logic       load,
    input  bit_count_t count,
    output logic       count_zero
);

    localparam int HALF    = CLK_DIV / 2;
    localparam int PHASE_W = (HALF > 1) ? $clog2(HALF) : 1;

    logic [PHASE_W-1:0] phase;
    logic               half_done;
    bit_count_t         remain;

    assign half_done = (phase == PHASE_W'(HALF - 1));

    // SD clock divider, ticks line up with the new sd_clk level
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= '0;
            sd_clk    <= 1'b0;
            tick_rise <= 1'b0;
            tick_fall <= 1'b0;
        end else begin
            tick_rise <= half_done & ~sd_clk;
            tick_fall <= half_done & sd_clk;
            if (half_done) begin
                phase  <= '0;
                sd_clk <= ~sd_clk;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Bit-time down counter, a fresh load wins over the decrement
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            remain <= '0;
        end else if (load) begin
            remain <= count;
        end else if (tick_fall && remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    assign count_zero = (remain == '0);

endmodule

// File: hdl/sd_crc7.sv
`timescale 1ns/1ps

module sd_crc7
    import sd_proto_pkg::*;
(
    input  logic  clk_fast,
    input  logic  arst_n,
    input  logic  clear,
    input  logic  enable,
    input  logic  din,
    output crc7_t crc
);

    logic feedback;

    assign feedback = crc[CRC_BITS-1] ^ din;

    // Direct form LFSR with no augmentation
    // Feeding din = crc MSB shifts the remainder out and leaves zeros
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[CRC_BITS-2:0], 1'b0} ^ ({CRC_BITS{feedback}} & CRC_POLY);
        end
    end

endmodule

// File: hdl/sd_cmd_shifter.sv
`timescale 1ns/1ps

module sd_cmd_shifter
    import sd_proto_pkg::*;
(
    input  logic                  clk_fast,
    input  logic                  arst_n,
    input  logic                  tick_rise,
    input  logic                  tick_fall,
    input  logic                  load_frame,
    input  cmd_req_t              req,
    input  logic                  send_en,
    input  logic                  crc_send,
    input  logic                  recv_en,
    input  logic                  cmd_in,
    output logic                  cmd_out,
    output logic                  line_start,
    output logic [FRAME_BITS-1:0] frame,
    output logic                  crc_ok
);

    logic [FRAME_BITS-1:0] shreg;
    logic                  tx_bit;
    logic                  crc_clear;
    logic                  crc_en;
    logic                  crc_din;
    crc7_t                 crc;

    // CRC field slots are zero, so OR-ing in the draining CRC gives CRC then end bit
    assign tx_bit = shreg[FRAME_BITS-1] | (crc_send & crc[CRC_BITS-1]);

    // Idle line keeps the CRC cleared, the start bit adds nothing to it
    assign crc_clear = load_frame | (~send_en & ~recv_en);
    assign crc_en    = (send_en & tick_fall) | (recv_en & tick_rise & ~crc_send);
    assign crc_din   = send_en ? (crc_send ? crc[CRC_BITS-1] : shreg[FRAME_BITS-1]) : cmd_in;

    sd_crc7 crc0 (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .clear    (crc_clear),
        .enable   (crc_en),
        .din      (crc_din),
        .crc      (crc)
    );

    // Outgoing bits leave from the top, incoming bits enter at the bottom
    always_ff @(posedge clk_fast) begin
        if (load_frame) begin
            shreg <= {1'b0, 1'b1, req.index, req.arg, {CRC_BITS{1'b0}}, 1'b1};
        end else if (send_en && tick_fall) begin
            shreg <= {shreg[FRAME_BITS-2:0], 1'b1};
        end else if (!send_en && tick_rise) begin
            shreg <= {shreg[FRAME_BITS-2:0], cmd_in};
        end
    end

    // CMD idles high between frames
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            cmd_out <= 1'b1;
        end else if (tick_fall) begin
            cmd_out <= send_en ? tx_bit : 1'b1;
        end
    end

    assign line_start = tick_rise & ~cmd_in;
    assign frame      = shreg;
    assign crc_ok     = (crc == shreg[CRC_BITS:1]);

endmodule

// File: hdl/sd_cmd_fsm.sv
`timescale 1ns/1ps

module sd_cmd_fsm
    import sd_proto_pkg::*, sd_ctrl_pkg::*;
(
    input  logic                  clk_fast,
    input  logic                  arst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  cmd_req_t              req,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output cmd_resp_t             resp,
    input  logic                  tick_rise,
    input  logic                  tick_fall,
    output logic                  load,
    output bit_count_t            count,
    input  logic                  count_zero,
    output logic                  load_frame,
    output logic                  send_en,
    output logic                  crc_send,
    output logic                  recv_en,
    input  logic                  line_start,
    input  logic [FRAME_BITS-1:0] frame,
    input  logic                  crc_ok,
    output logic                  cmd_oe
);

    seq_state_t state;
    seq_state_t state_n;
    logic       crc_phase;
    logic       crc_phase_n;
    logic       resp_valid_n;
    logic       resp_load;
    logic       accept;
    resp_kind_t kind_q;
    cmd_resp_t  resp_n;

    assign accept     = req_valid & req_ready;
    assign req_ready  = (state == IDLE);
    assign load_frame = accept;
    // The last bit time after the end bit is no longer driven
    assign send_en    = (state == SEND) & ~(crc_phase & count_zero);
    assign crc_send   = crc_phase;
    assign recv_en    = (state == RECV);

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_n      = state;
        crc_phase_n  = crc_phase;
        resp_valid_n = resp_valid;
        resp_load    = 1'b0;
        load         = 1'b0;
        count        = '0;
        // Judgement of the captured frame
        resp_n.index   = frame[FRAME_BITS-3 -: INDEX_BITS];
        resp_n.arg     = frame[CRC_BITS+1 +: ARG_BITS];
        resp_n.crc_err = ~crc_ok;
        resp_n.end_err = ~frame[0];
        resp_n.timeout = 1'b0;

        case (state)
            IDLE: begin
                if (accept) begin
                    state_n     = SEND;
                    load        = 1'b1;
                    count       = bit_count_t'(CRC_COVER_BITS);
                    crc_phase_n = 1'b0;
                end
            end
            SEND: begin
                if (count_zero && !crc_phase) begin
                    // CRC7 and end bit follow
                    load        = 1'b1;
                    count       = bit_count_t'(CRC_BITS + 1);
                    crc_phase_n = 1'b1;
                end else if (count_zero && tick_fall) begin
                    load        = 1'b1;
                    crc_phase_n = 1'b0;
                    if (kind_q == RESP_R48) begin
                        state_n = WAIT_START;
                        count   = bit_count_t'(NCR_MAX);
                    end else begin
                        state_n = GAP;
                        count   = bit_count_t'(NCC_BITS);
                    end
                end
            end
            WAIT_START: begin
                if (line_start) begin
                    // Start bit already sampled
                    state_n = RECV;
                    load    = 1'b1;
                    count   = bit_count_t'(CRC_COVER_BITS - 1);
                end else if (count_zero) begin
                    state_n        = DELIVER;
                    resp_n         = '0;
                    resp_n.timeout = 1'b1;
                    resp_load      = 1'b1;
                    resp_valid_n   = 1'b1;
                end
            end
            RECV: begin
                if (count_zero && tick_rise) begin
                    if (!crc_phase) begin
                        load        = 1'b1;
                        count       = bit_count_t'(CRC_BITS + 1);
                        crc_phase_n = 1'b1;
                    end else begin
                        state_n     = DELIVER;
                        crc_phase_n = 1'b0;
                    end
                end
            end
            DELIVER: begin
                if (!resp_valid) begin
                    // Frame holds its last bit from here on
                    resp_load    = 1'b1;
                    resp_valid_n = 1'b1;
                end else if (resp_ready) begin
                    resp_valid_n = 1'b0;
                    state_n      = GAP;
                    load         = 1'b1;
                    count        = bit_count_t'(NCC_BITS);
                end
            end
            GAP: begin
                if (count_zero) begin
                    state_n = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    // ====================
    // State registers
    // ====================
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            crc_phase  <= 1'b0;
            resp_valid <= 1'b0;
            kind_q     <= RESP_NONE;
            cmd_oe     <= 1'b0;
        end else begin
            state      <= state_n;
            crc_phase  <= crc_phase_n;
            resp_valid <= resp_valid_n;
            if (accept) begin
                kind_q <= req.resp_kind;
            end
            // Enable moves with the bit edges, 48 SD clocks per frame
            if (tick_fall) begin
                cmd_oe <= send_en;
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (resp_load) begin
            resp <= resp_n;
        end
    end

endmodule

// File: hdl/sd_cmd_host.sv
`timescale 1ns/1ps

module sd_cmd_host
    import sd_proto_pkg::*, sd_ctrl_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic      clk_fast,
    input  logic      arst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  cmd_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output cmd_resp_t resp,
    output logic      sd_clk,
    output logic      cmd_out,
    output logic      cmd_oe,
    input  logic      cmd_in
);

    // Slot to sequencer
    logic      seq_req_valid;
    logic      seq_req_ready;
    cmd_req_t  seq_req;
    // Sequencer to slot
    logic      seq_resp_valid;
    logic      seq_resp_ready;
    cmd_resp_t seq_resp;

    // Timer and shifter controls
    logic                  tick_rise;
    logic                  tick_fall;
    logic                  tmr_load;
    bit_count_t            tmr_count;
    logic                  count_zero;
    logic                  load_frame;
    logic                  send_en;
    logic                  crc_send;
    logic                  recv_en;
    logic                  line_start;
    logic [FRAME_BITS-1:0] frame;
    logic                  crc_ok;

    // ====================
    // Request and response slots
    // ====================
    sd_slot_reg #(.payload_t(cmd_req_t)) req_slot (
        .clk_fast  (clk_fast),
        .arst_n    (arst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (seq_req_valid),
        .out_ready (seq_req_ready),
        .out_data  (seq_req)
    );

    sd_slot_reg #(.payload_t(cmd_resp_t)) resp_slot (
        .clk_fast  (clk_fast),
        .arst_n    (arst_n),
        .in_valid  (seq_resp_valid),
        .in_ready  (seq_resp_ready),
        .in_data   (seq_resp),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (resp)
    );

    // ====================
    // Line side
    // ====================
    sd_bit_timer #(.CLK_DIV(CLK_DIV)) bit_timer (
        .clk_fast   (clk_fast),
        .arst_n     (arst_n),
        .sd_clk     (sd_clk),
        .tick_rise  (tick_rise),
        .tick_fall  (tick_fall),
        .load       (tmr_load),
        .count      (tmr_count),
        .count_zero (count_zero)
    );

    sd_cmd_shifter shifter (
        .clk_fast   (clk_fast),
        .arst_n     (arst_n),
        .tick_rise  (tick_rise),
        .tick_fall  (tick_fall),
        .load_frame (load_frame),
        .req        (seq_req),
        .send_en    (send_en),
        .crc_send   (crc_send),
        .recv_en    (recv_en),
        .cmd_in     (cmd_in),
        .cmd_out    (cmd_out),
        .line_start (line_start),
        .frame      (frame),
        .crc_ok     (crc_ok)
    );

    sd_cmd_fsm fsm (
        .clk_fast   (clk_fast),
        .arst_n     (arst_n),
        .req_valid  (seq_req_valid),
        .req_ready  (seq_req_ready),
        .req        (seq_req),
        .resp_valid (seq_resp_valid),
        .resp_ready (seq_resp_ready),
        .resp       (seq_resp),
        .tick_rise  (tick_rise),
        .tick_fall  (tick_fall),
        .load       (tmr_load),
        .count      (tmr_count),
        .count_zero (count_zero),
        .load_frame (load_frame),
        .send_en    (send_en),
        .crc_send   (crc_send),
        .recv_en    (recv_en),
        .line_start (line_start),
        .frame      (frame),
        .crc_ok     (crc_ok),
        .cmd_oe     (cmd_oe)
    );

endmodule

// File: bench/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
    input  logic       sd_clk,
    input  logic       cmd_out,
    input  logic       cmd_oe,
    // 0 normal, 1 bad CRC, 2 bad end bit, 3 silent
    input  logic [1:0] mode,
    input  logic [3:0] delay_bits,
    output logic       cmd_in
);

    logic [47:0] rx;
    logic [47:0] tx;
    logic [6:0]  crc;
    logic        fb;
    int          i;

    initial begin
        cmd_in = 1'b1;
        forever begin
            // Wait for the start of a host frame
            @(posedge sd_clk);
            while (!cmd_oe) begin
                @(posedge sd_clk);
            end
            rx = {47'd0, cmd_out};
            for (i = 1; i < 48; i++) begin
                @(posedge sd_clk);
                rx = {rx[46:0], cmd_out};
            end
            if (mode != 2'd3) begin
                tx = {2'b00, rx[45:40], ~rx[39:8], 8'd0};
                crc = '0;
                for (i = 47; i >= 8; i--) begin
                    fb  = crc[6] ^ tx[i];
                    crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
                end
                tx[7:1] = (mode == 2'd1) ? (crc ^ 7'h01) : crc;
                tx[0]   = (mode != 2'd2);
                repeat (delay_bits) @(negedge sd_clk);
                for (i = 47; i >= 0; i--) begin
                    @(negedge sd_clk);
                    #2;
                    cmd_in = tx[i];
                end
                @(negedge sd_clk);
                #2;
                cmd_in = 1'b1;
            end
        end
    end

endmodule

// File: bench/tb_sd_cmd_host.sv
`timescale 1ns/1ps

module tb_sd_cmd_host
    import sd_proto_pkg::*, sd_ctrl_pkg::*;
;

    localparam int CLK_DIV   = 4;
    localparam int N_PHASE   = 12;
    localparam int N_TOTAL   = 4 * N_PHASE;
    localparam int MAX_STALL = 1500;
    localparam longint WATCH_CYCLES =
        longint'(N_TOTAL) * ((48 + NCR_MAX + 48 + NCC_BITS) * 2 * CLK_DIV + MAX_STALL)
        + 4 * 1000 + 100;

    typedef struct packed {
        logic [47:0] frame;
        logic [1:0]  mode;
        logic [3:0]  delay;
    } cmd_exp_t;

    logic       clk_fast;
    logic       arst_n;
    logic       req_valid;
    logic       req_ready;
    cmd_req_t   req;
    logic       resp_valid;
    logic       resp_ready;
    cmd_resp_t  resp;
    logic       sd_clk;
    logic       cmd_out;
    logic       cmd_oe;
    logic       cmd_in;
    logic [1:0] card_mode;
    logic [3:0] card_delay;

    integer     seed = 32'hae4a_9023;
    int         errors;
    int         checks;
    string      cur_test;
    cmd_exp_t   cmd_q[$];
    cmd_resp_t  resp_q[$];
    cmd_exp_t   cur_cmd;
    logic [47:0] cap;
    int         bit_cnt;
    int         frames_pending;
    bit         stall_on;
    bit         held_seen;

    sd_cmd_host #(.CLK_DIV(CLK_DIV)) dut0 (
        .clk_fast   (clk_fast),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .sd_clk     (sd_clk),
        .cmd_out    (cmd_out),
        .cmd_oe     (cmd_oe),
        .cmd_in     (cmd_in)
    );

    sd_card_model card0 (
        .sd_clk     (sd_clk),
        .cmd_out    (cmd_out),
        .cmd_oe     (cmd_oe),
        .mode       (card_mode),
        .delay_bits (card_delay),
        .cmd_in     (cmd_in)
    );

    initial begin
        clk_fast = 1'b0;
        forever #10 clk_fast = ~clk_fast;
    end

    // Serial CRC7 over x^7 + x^3 + 1 with the MSB first
    function automatic crc7_t calc_crc7(input logic [39:0] bits);
        crc7_t c;
        logic  fb;
        c = '0;
        for (int k = 39; k >= 0; k--) begin
            fb = c[6] ^ bits[k];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic int urand(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    // ====================
    // Frame monitor
    // ====================
    always @(posedge sd_clk) begin
        if (cmd_oe) begin
            if (bit_cnt == 0) begin
                checks++;
                assert (cmd_q.size() != 0) else begin
                    $display("Frame started on CMD with no request outstanding");
                    errors++;
                end
                if (cmd_q.size() != 0) begin
                    cur_cmd = cmd_q.pop_front();
                end
                card_mode  <= cur_cmd.mode;
                card_delay <= cur_cmd.delay;
            end
            cap = {cap[46:0], cmd_out};
            bit_cnt++;
        end else if (bit_cnt != 0) begin
            checks += 2;
            assert (bit_cnt == 48) else begin
                $display("ERROR %s bits: expected 48, actual %0d", cur_test, bit_cnt);
                errors++;
            end
            assert (cap == cur_cmd.frame) else begin
                $display("ERROR %s frame: expected %h, actual %h",
                         cur_test, cur_cmd.frame, cap);
                errors++;
            end
            frames_pending--;
            bit_cnt = 0;
        end
    end

    // ====================
    // Response consumer
    // ====================
    initial begin
        bit   decided;
        int   stall_left;
        cmd_resp_t exp;
        decided    = 1'b0;
        stall_left = 0;
        resp_ready = 1'b0;
        forever begin
            @(posedge clk_fast);
            #2;
            if (resp_valid && !decided) begin
                decided = 1'b1;
                if (stall_on) begin
                    stall_left = (urand(3) == 0) ? MAX_STALL : urand(8);
                end
            end
            if (stall_left > 0) begin
                resp_ready = 1'b0;
                stall_left--;
            end else begin
                resp_ready = 1'b1;
            end
            #16;
            if (resp_valid && !resp_ready && !req_ready) begin
                held_seen = 1'b1;
            end
            if (resp_valid && resp_ready) begin
                decided = 1'b0;
                checks++;
                assert (resp_q.size() != 0) else begin
                    $display("Response delivered while none was expected");
                    errors++;
                end
                if (resp_q.size() != 0) begin
                    exp = resp_q.pop_front();
                    assert (resp == exp) else begin
                        $display("ERROR %s response: expected %h, actual %h",
                                 cur_test, exp, resp);
                        errors++;
                    end
                end
            end
        end
    end

    // Holds one random command on req until the slot takes it
    task automatic send_random(input bit allow_none, input bit allow_err);
        cmd_req_t  r;
        cmd_exp_t  e;
        cmd_resp_t x;
        r.index     = 6'(urand(64));
        r.arg       = $random(seed);
        r.resp_kind = (allow_none && urand(2) == 0) ? RESP_NONE : RESP_R48;
        e.frame     = {2'b01, r.index, r.arg, calc_crc7({2'b01, r.index, r.arg}), 1'b1};
        e.delay     = 4'(2 + urand(9));
        if (r.resp_kind == RESP_NONE) begin
            e.mode = 2'd3;
        end else begin
            e.mode = allow_err ? 2'(urand(4)) : 2'd0;
        end
        x = {r.index, ~r.arg, 3'b000};
        if (e.mode == 2'd1) x.crc_err = 1'b1;
        if (e.mode == 2'd2) x.end_err = 1'b1;
        if (e.mode == 2'd3) x = {INDEX_BITS'(0), ARG_BITS'(0), 3'b001};
        req_valid = 1'b1;
        req       = r;
        while (!req_ready) begin
            @(posedge clk_fast);
            #2;
        end
        @(posedge clk_fast);
        cmd_q.push_back(e);
        frames_pending++;
        if (r.resp_kind == RESP_R48) begin
            resp_q.push_back(x);
        end
        #2;
        req_valid = 1'b0;
    endtask

    task automatic run_phase(input string name, input bit allow_none,
                             input bit allow_err, input bit stalls);
        int err0;
        int chk0;
        err0     = errors;
        chk0     = checks;
        cur_test = name;
        stall_on = stalls;
        for (int n = 0; n < N_PHASE; n++) begin
            send_random(allow_none, allow_err);
        end
        while (resp_q.size() != 0 || frames_pending != 0) begin
            @(posedge clk_fast);
        end
        repeat ((NCC_BITS + 4) * 2 * CLK_DIV) @(posedge clk_fast);
        #2;
        $display("%-16s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        arst_n         = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        card_mode      = 2'd3;
        card_delay     = 4'd2;
        errors         = 0;
        checks         = 0;
        bit_cnt        = 0;
        frames_pending = 0;
        stall_on       = 1'b0;
        held_seen      = 1'b0;
        cur_test       = "reset_state";
        repeat (8) @(posedge clk_fast);
        #2;
        arst_n = 1'b1;
        @(posedge clk_fast);
        #2;
        checks++;
        assert (!resp_valid && !cmd_oe && !sd_clk && cmd_out && req_ready) else begin
            $display("Outputs after reset are not at their idle levels");
            errors++;
        end
        $display("%-16s %0d checks, %0d errors", cur_test, checks, errors);

        run_phase("frames_r48", 1'b0, 1'b0, 1'b0);
        run_phase("error_flags", 1'b0, 1'b1, 1'b0);
        run_phase("resp_none_mix", 1'b1, 1'b0, 1'b0);
        held_seen = 1'b0;
        run_phase("resp_stalls", 1'b1, 1'b1, 1'b1);
        checks++;
        assert (held_seen) else begin
            $display("req_ready never fell while the response slot was held");
            errors++;
        end

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the worst case per command
    initial begin
        #(WATCH_CYCLES * 20);
        $display("Watchdog expired before all commands completed");
        $display("test failed");
        $finish;
    end

endmodule

// File: sd_cmd_host.f
hdl/sd_proto_pkg.sv
hdl/sd_ctrl_pkg.sv
hdl/sd_slot_reg.sv
hdl/sd_bit_timer.sv
hdl/sd_crc7.sv
hdl/sd_cmd_shifter.sv
hdl/sd_cmd_fsm.sv
hdl/sd_cmd_host.sv
bench/sd_card_model.sv
bench/tb_sd_cmd_host.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the SD command host testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f sd_cmd_host.f --top-module tb_sd_cmd_host -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
exit 1
